// ==== design/laser_geom_pkg.sv ====
package laser_geom_pkg;

    // grid is GRID_SIZE by GRID_SIZE, coordinates 0 to 15.
    localparam int unsigned GRID_SIZE   = 16;

    // points per frame.
    localparam int unsigned NUM_POINTS  = 40;

    localparam int unsigned RADIUS_SQ   = 16;   // radius 4, boundary counts as covered.
    localparam int unsigned WINDOW_HALF = 4;    // refinement window is centre +/- 4.

    // one grid coordinate.
    typedef logic [3:0] coord_t;

    // covered point count, 0 to NUM_POINTS.
    typedef logic [5:0] point_cnt_t;

    // squared distance, at most 15*15 + 15*15 = 450.
    typedef logic [8:0] dist_sq_t;

endpackage

// ==== design/laser_ctrl_pkg.sv ====
package laser_ctrl_pkg;

    localparam int unsigned NUM_ROUNDS    = 5;     // one full-grid round plus four windowed.
    localparam int unsigned COVER_LATENCY = 42;    // start cycle to done cycle.

    // point buffer index.
    typedef logic [5:0] point_addr_t;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_LOAD       = 3'd1,
        ST_SCAN_C1    = 3'd2,
        ST_SCAN_C2    = 3'd3,
        ST_NEXT_ROUND = 3'd4,
        ST_FINISH     = 3'd5
    } search_state_t;

endpackage

// ==== design/cover_if.sv ====
interface cover_if;
    import laser_geom_pkg::*;

    logic       start;      // one-cycle request.
    coord_t     cand_x;
    coord_t     cand_y;
    coord_t     fixed_x;    // centre of the other circle.
    coord_t     fixed_y;
    logic       union_en;   // also count points inside the fixed circle.
    logic       done;
    point_cnt_t count;

    modport search (
        output start, cand_x, cand_y, fixed_x, fixed_y, union_en,
        input  done, count
    );

    modport counter (
        input  start, cand_x, cand_y, fixed_x, fixed_y, union_en,
        output done, count
    );

endinterface

// ==== design/point_buffer.sv ====
module point_buffer (
    input  logic                        CLK,
    input  logic                        wr_en,
    input  laser_ctrl_pkg::point_addr_t wr_addr,
    input  laser_geom_pkg::coord_t      wr_x,
    input  laser_geom_pkg::coord_t      wr_y,
    input  laser_ctrl_pkg::point_addr_t rd_addr,
    output laser_geom_pkg::coord_t      rd_x,
    output laser_geom_pkg::coord_t      rd_y
);
    import laser_geom_pkg::*;

    coord_t mem_x [NUM_POINTS];
    coord_t mem_y [NUM_POINTS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem_x[wr_addr] <= wr_x;
            mem_y[wr_addr] <= wr_y;
        end
    end

    // registered read, data follows the address by one cycle.
    always_ff @(posedge CLK) begin
        rd_x <= mem_x[rd_addr];
        rd_y <= mem_y[rd_addr];
    end

endmodule

// ==== design/cover_counter.sv ====
module cover_counter (
    input  logic                        CLK,
    input  logic                        RST,
    input  laser_geom_pkg::coord_t      rd_x,
    input  laser_geom_pkg::coord_t      rd_y,
    output laser_ctrl_pkg::point_addr_t rd_addr,
    cover_if.counter                    cov
);
    import laser_geom_pkg::*;
    import laser_ctrl_pkg::*;

    logic       busy;
    logic [5:0] cyc;        // cycles since the start cycle.
    logic       rd_vld;
    logic       in_cand;
    logic       in_fixed;
    logic       hit;
    point_cnt_t acc;

    function automatic dist_sq_t dist_sq(coord_t ax, coord_t ay, coord_t bx, coord_t by);
        coord_t dx;
        coord_t dy;
        dx = (ax > bx) ? ax - bx : bx - ax;
        dy = (ay > by) ? ay - by : by - ay;
        return dist_sq_t'(dx) * dist_sq_t'(dx) + dist_sq_t'(dy) * dist_sq_t'(dy);
    endfunction

    // buffer output holds point cyc-1 during cycles 1 to NUM_POINTS.
    assign rd_vld   = busy && (cyc <= 6'(NUM_POINTS));
    assign in_cand  = dist_sq(rd_x, rd_y, cov.cand_x, cov.cand_y) <= dist_sq_t'(RADIUS_SQ);
    assign in_fixed = dist_sq(rd_x, rd_y, cov.fixed_x, cov.fixed_y) <= dist_sq_t'(RADIUS_SQ);

    assign cov.count = acc;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy     <= 1'b0;
            cyc      <= '0;
            rd_addr  <= '0;
            hit      <= 1'b0;
            acc      <= '0;
            cov.done <= 1'b0;
        end else begin
            hit      <= rd_vld && (in_cand || (cov.union_en && in_fixed));
            cov.done <= busy && (cyc == 6'(COVER_LATENCY - 1));
            if (cov.start) begin
                // address 0 is already being read in the start cycle.
                busy    <= 1'b1;
                cyc     <= 6'd1;
                rd_addr <= point_addr_t'(1);
                acc     <= '0;
            end else if (busy) begin
                cyc <= cyc + 6'd1;
                if (cyc < 6'(NUM_POINTS - 1)) begin
                    rd_addr <= point_addr_t'(cyc + 6'd1);
                end else begin
                    rd_addr <= '0;    // park at 0 for the next request.
                end
                acc <= acc + point_cnt_t'(hit);
                if (cyc == 6'(COVER_LATENCY - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== design/center_search.sv ====
module center_search (
    input  logic                        CLK,
    input  logic                        RST,
    input  laser_geom_pkg::coord_t      x,
    input  laser_geom_pkg::coord_t      y,
    output logic                        wr_en,
    output laser_ctrl_pkg::point_addr_t wr_addr,
    output laser_geom_pkg::coord_t      wr_x,
    output laser_geom_pkg::coord_t      wr_y,
    output laser_geom_pkg::coord_t      c1_x,
    output laser_geom_pkg::coord_t      c1_y,
    output laser_geom_pkg::coord_t      c2_x,
    output laser_geom_pkg::coord_t      c2_y,
    output logic                        done,
    cover_if.search                     cov
);
    import laser_geom_pkg::*;
    import laser_ctrl_pkg::*;

    search_state_t state;
    logic [2:0]    round;
    point_addr_t   load_cnt;
    logic          pending;     // cover request outstanding.
    point_cnt_t    best_cnt;
    coord_t        pos_x;
    coord_t        pos_y;
    coord_t        x_lo;
    coord_t        x_hi;
    coord_t        y_hi;

    logic          scanning;
    logic          row_end;
    logic          scan_end;
    logic          better;
    logic          load_last;
    logic          last_round;
    logic          scan_setup;
    coord_t        nxt_cx;
    coord_t        nxt_cy;
    logic          nxt_full;

    function automatic coord_t win_lo(coord_t c, logic full);
        if (full || (c < coord_t'(WINDOW_HALF))) begin
            return '0;
        end
        return c - coord_t'(WINDOW_HALF);
    endfunction

    function automatic coord_t win_hi(coord_t c, logic full);
        if (full || (c > coord_t'(GRID_SIZE - 1 - WINDOW_HALF))) begin
            return coord_t'(GRID_SIZE - 1);
        end
        return c + coord_t'(WINDOW_HALF);
    endfunction

    assign scanning   = (state == ST_SCAN_C1) || (state == ST_SCAN_C2);
    assign row_end    = (pos_x == x_hi);
    assign scan_end   = row_end && (pos_y == y_hi);
    assign better     = (cov.count >= best_cnt);    // later position wins ties.
    assign load_last  = (load_cnt == point_addr_t'(NUM_POINTS - 1));
    assign last_round = (round == 3'(NUM_ROUNDS - 1));

    // a new scan begins after loading, after the c1 scan, and at each new round.
    assign scan_setup = ((state == ST_LOAD) && load_last)
                     || ((state == ST_SCAN_C1) && cov.done && scan_end)
                     || ((state == ST_NEXT_ROUND) && !last_round);

    // centre of the scan about to begin; round 0 searches the whole grid.
    always_comb begin
        if (state == ST_SCAN_C1) begin
            nxt_cx   = c2_x;
            nxt_cy   = c2_y;
            nxt_full = (round == 3'd0);
        end else begin
            nxt_cx   = c1_x;
            nxt_cy   = c1_y;
            nxt_full = (state == ST_LOAD);
        end
    end

    assign cov.start    = scanning && !pending;
    assign cov.cand_x   = pos_x;
    assign cov.cand_y   = pos_y;
    assign cov.fixed_x  = (state == ST_SCAN_C2) ? c1_x : c2_x;
    assign cov.fixed_y  = (state == ST_SCAN_C2) ? c1_y : c2_y;
    assign cov.union_en = (round != 3'd0) || (state == ST_SCAN_C2);

    assign wr_en   = (state == ST_LOAD);
    assign wr_addr = load_cnt;
    assign wr_x    = x;
    assign wr_y    = y;
    assign done    = (state == ST_FINISH);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state    <= ST_IDLE;
            round    <= '0;
            load_cnt <= '0;
            pending  <= 1'b0;
            c1_x     <= '0;
            c1_y     <= '0;
            c2_x     <= '0;
            c2_y     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    round    <= '0;
                    load_cnt <= '0;
                    c1_x     <= '0;
                    c1_y     <= '0;
                    c2_x     <= '0;
                    c2_y     <= '0;
                    state    <= ST_LOAD;
                end
                ST_LOAD: begin
                    load_cnt <= load_cnt + 6'd1;
                    if (load_last) begin
                        state <= ST_SCAN_C1;
                    end
                end
                ST_SCAN_C1, ST_SCAN_C2: begin
                    if (cov.start) begin
                        pending <= 1'b1;
                    end else if (cov.done) begin
                        pending <= 1'b0;
                        if (better && (state == ST_SCAN_C1)) begin
                            c1_x <= pos_x;
                            c1_y <= pos_y;
                        end
                        if (better && (state == ST_SCAN_C2)) begin
                            c2_x <= pos_x;
                            c2_y <= pos_y;
                        end
                        if (scan_end) begin
                            state <= (state == ST_SCAN_C1) ? ST_SCAN_C2 : ST_NEXT_ROUND;
                        end
                    end
                end
                ST_NEXT_ROUND: begin
                    if (last_round) begin
                        state <= ST_FINISH;
                    end else begin
                        round <= round + 3'd1;
                        state <= ST_SCAN_C1;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // window bounds, scan position and best count of the current scan.
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            x_lo     <= '0;
            x_hi     <= '0;
            y_hi     <= '0;
            pos_x    <= '0;
            pos_y    <= '0;
            best_cnt <= '0;
        end else if (scan_setup) begin
            x_lo     <= win_lo(nxt_cx, nxt_full);
            x_hi     <= win_hi(nxt_cx, nxt_full);
            y_hi     <= win_hi(nxt_cy, nxt_full);
            pos_x    <= win_lo(nxt_cx, nxt_full);
            pos_y    <= win_lo(nxt_cy, nxt_full);
            best_cnt <= '0;
        end else if (scanning && cov.done) begin
            if (better) begin
                best_cnt <= cov.count;
            end
            if (!row_end) begin
                pos_x <= pos_x + 4'd1;
            end else begin
                pos_x <= x_lo;          // row-major, next row.
                pos_y <= pos_y + 4'd1;
            end
        end
    end

endmodule

// ==== design/laser.sv ====
module laser (
    input  logic                   CLK,
    input  logic                   RST,
    input  laser_geom_pkg::coord_t x,
    input  laser_geom_pkg::coord_t y,
    output laser_geom_pkg::coord_t c1_x,
    output laser_geom_pkg::coord_t c1_y,
    output laser_geom_pkg::coord_t c2_x,
    output laser_geom_pkg::coord_t c2_y,
    output logic                   done
);
    import laser_geom_pkg::*;
    import laser_ctrl_pkg::*;

    logic        wr_en;
    point_addr_t wr_addr;
    coord_t      wr_x;
    coord_t      wr_y;
    point_addr_t rd_addr;
    coord_t      rd_x;
    coord_t      rd_y;

    cover_if cov ();

    point_buffer point_buffer_i (
        .CLK     (CLK),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_x    (wr_x),
        .wr_y    (wr_y),
        .rd_addr (rd_addr),
        .rd_x    (rd_x),
        .rd_y    (rd_y)
    );

    cover_counter cover_counter_i (
        .CLK     (CLK),
        .RST     (RST),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .rd_addr (rd_addr),
        .cov     (cov.counter)
    );

    center_search center_search_i (
        .CLK     (CLK),
        .RST     (RST),
        .x       (x),
        .y       (y),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_x    (wr_x),
        .wr_y    (wr_y),
        .c1_x    (c1_x),
        .c1_y    (c1_y),
        .c2_x    (c2_x),
        .c2_y    (c2_y),
        .done    (done),
        .cov     (cov.search)
    );

endmodule

// ==== verif/laser_model.svh ====
`ifndef LASER_MODEL_SVH
`define LASER_MODEL_SVH

// xorshift32 step for the random frames.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
endfunction

function automatic int dist2(input int ax, input int ay, input int bx, input int by);
    return (ax - bx) * (ax - bx) + (ay - by) * (ay - by);
endfunction

// points inside the circle at (cx, cy), or inside (fx, fy) as well when use_fixed is set.
function automatic int cover_count(input coord_t px [NUM_POINTS], input coord_t py [NUM_POINTS],
                                   input int cx, input int cy,
                                   input int fx, input int fy, input bit use_fixed);
    int n;
    n = 0;
    for (int i = 0; i < int'(NUM_POINTS); i++) begin
        if (dist2(int'(px[i]), int'(py[i]), cx, cy) <= int'(RADIUS_SQ)) begin
            n++;
        end else if (use_fixed
                     && dist2(int'(px[i]), int'(py[i]), fx, fy) <= int'(RADIUS_SQ)) begin
            n++;
        end
    end
    return n;
endfunction

// row-major scan of the clamped window around (cx, cy), later positions win ties.
function automatic void scan_window(input coord_t px [NUM_POINTS], input coord_t py [NUM_POINTS],
                                    input int cx, input int cy, input bit full,
                                    input int fx, input int fy, input bit use_fixed,
                                    output int bx, output int by);
    int h;
    int lo_x;
    int hi_x;
    int lo_y;
    int hi_y;
    int best;
    int n;
    h    = full ? int'(GRID_SIZE) : int'(WINDOW_HALF);
    lo_x = (cx - h < 0) ? 0 : cx - h;
    hi_x = (cx + h > int'(GRID_SIZE) - 1) ? int'(GRID_SIZE) - 1 : cx + h;
    lo_y = (cy - h < 0) ? 0 : cy - h;
    hi_y = (cy + h > int'(GRID_SIZE) - 1) ? int'(GRID_SIZE) - 1 : cy + h;
    best = 0;
    bx   = lo_x;
    by   = lo_y;
    for (int yy = lo_y; yy <= hi_y; yy++) begin
        for (int xx = lo_x; xx <= hi_x; xx++) begin
            n = cover_count(px, py, xx, yy, fx, fy, use_fixed);
            if (n >= best) begin
                best = n;
                bx   = xx;
                by   = yy;
            end
        end
    end
endfunction

function automatic void model_search(input coord_t px [NUM_POINTS], input coord_t py [NUM_POINTS],
                                     output coord_t e1x, output coord_t e1y,
                                     output coord_t e2x, output coord_t e2y, output int cov);
    int ax;
    int ay;
    int bx;
    int by;
    scan_window(px, py, 0, 0, 1'b1, 0, 0, 1'b0, ax, ay);     // circle 1 alone.
    scan_window(px, py, 0, 0, 1'b1, ax, ay, 1'b1, bx, by);
    for (int r = 1; r < int'(NUM_ROUNDS); r++) begin
        scan_window(px, py, ax, ay, 1'b0, bx, by, 1'b1, ax, ay);
        scan_window(px, py, bx, by, 1'b0, ax, ay, 1'b1, bx, by);
    end
    e1x = coord_t'(ax);
    e1y = coord_t'(ay);
    e2x = coord_t'(bx);
    e2y = coord_t'(by);
    cov = cover_count(px, py, ax, ay, bx, by, 1'b1);
endfunction

`endif

// ==== verif/laser_tb.sv ====
module laser_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import laser_geom_pkg::*;
    import laser_ctrl_pkg::*;

    `include "laser_model.svh"

    localparam int NUM_FRAMES   = 8;
    localparam int RST_CYCLES   = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int WIN_SIDE     = 2 * int'(WINDOW_HALF) + 1;
    localparam int FRAME_CYCLES = (2 * int'(GRID_SIZE * GRID_SIZE)
                                  + 2 * (int'(NUM_ROUNDS) - 1) * WIN_SIDE * WIN_SIDE) * 44 + 100;
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * FRAME_CYCLES * 40;

    typedef enum logic [1:0] {FRAME_SAME, FRAME_CLUSTERS, FRAME_RANDOM} frame_kind_t;

    typedef struct packed {
        frame_kind_t kind;
        int          ax;
        int          ay;
        int          bx;
        int          by;
        int          exp_cov;     // -1 takes the coverage from the model.
    } frame_entry_t;

    localparam frame_entry_t FRAME_TABLE [NUM_FRAMES] = '{
        '{FRAME_SAME,      7,  7,  0,  0, 40},
        '{FRAME_SAME,      0,  0,  0,  0, 40},
        '{FRAME_SAME,     15,  3,  0,  0, 40},
        '{FRAME_CLUSTERS,  1,  1, 14, 14, 40},
        '{FRAME_CLUSTERS,  0, 15, 15,  0, 40},
        '{FRAME_RANDOM,    0,  0,  0,  0, -1},
        '{FRAME_RANDOM,    0,  0,  0,  0, -1},
        '{FRAME_RANDOM,    0,  0,  0,  0, -1}
    };

    logic        CLK;
    logic        RST;
    coord_t      x;
    coord_t      y;
    coord_t      c1_x;
    coord_t      c1_y;
    coord_t      c2_x;
    coord_t      c2_y;
    logic        done;
    coord_t      frame_x [NUM_POINTS];
    coord_t      frame_y [NUM_POINTS];
    logic [31:0] rng;
    int          test_errs;
    int          pass_count;
    int          fail_count;

    laser laser_i (
        .CLK  (CLK),
        .RST  (RST),
        .x    (x),
        .y    (y),
        .c1_x (c1_x),
        .c1_y (c1_y),
        .c2_x (c2_x),
        .c2_y (c2_y),
        .done (done)
    );

    always #20 CLK = ~CLK;     // 40 ns period.

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input point_cnt_t got, input point_cnt_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_cleared();
        check_flag("done", done, 1'b0);
        check_coord("c1_x", c1_x, '0);
        check_coord("c1_y", c1_y, '0);
        check_coord("c2_x", c2_x, '0);
        check_coord("c2_y", c2_y, '0);
    endtask

    task automatic check_centres(input coord_t e1x, input coord_t e1y,
                                 input coord_t e2x, input coord_t e2y);
        check_coord("c1_x", c1_x, e1x);
        check_coord("c1_y", c1_y, e1y);
        check_coord("c2_x", c2_x, e2x);
        check_coord("c2_y", c2_y, e2y);
    endtask

    function automatic string kind_name(input frame_kind_t k);
        case (k)
            FRAME_SAME:     return "single point";
            FRAME_CLUSTERS: return "two clusters";
            default:        return "random";
        endcase
    endfunction

    function automatic coord_t clamp_coord(input int v);
        if (v < 0) begin
            return '0;
        end
        return (v > int'(GRID_SIZE) - 1) ? coord_t'(GRID_SIZE - 1) : coord_t'(v);
    endfunction

    task automatic build_frame(input frame_entry_t e);
        int cx;
        int cy;
        for (int i = 0; i < int'(NUM_POINTS); i++) begin
            cx = (i < int'(NUM_POINTS) / 2) ? e.ax : e.bx;
            cy = (i < int'(NUM_POINTS) / 2) ? e.ay : e.by;
            case (e.kind)
                FRAME_SAME: begin
                    frame_x[i] = clamp_coord(e.ax);
                    frame_y[i] = clamp_coord(e.ay);
                end
                FRAME_CLUSTERS: begin
                    frame_x[i] = clamp_coord(cx + i % 3 - 1);    // 3 by 3 spread.
                    frame_y[i] = clamp_coord(cy + (i / 3) % 3 - 1);
                end
                default: begin
                    rng        = xorshift32(rng);
                    frame_x[i] = rng[3:0];
                    frame_y[i] = rng[11:8];
                end
            endcase
        end
    endtask

    task automatic load_frame();
        @(posedge CLK);                  // idle cycle.
        for (int i = 0; i < int'(NUM_POINTS); i++) begin
            #(DRIVE_DELAY);
            x = frame_x[i];
            y = frame_y[i];
            @(negedge CLK);
            check_cleared();
            @(posedge CLK);
        end
        #(DRIVE_DELAY);
        x = '0;
        y = '0;
    endtask

    task automatic wait_done(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < FRAME_CYCLES) begin
            @(negedge CLK);
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                n++;
            end
        end
    endtask

    task automatic report_test(input int idx, input string what);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d %s: ok", idx, what);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", idx, what, test_errs);
        end
    endtask

    initial begin
        frame_entry_t e;
        coord_t       m1x;
        coord_t       m1y;
        coord_t       m2x;
        coord_t       m2y;
        int           m_cov;
        int           exp_cov;
        int           dut_cov;
        bit           seen;
        string        what;
        CLK        = 1'b0;
        RST        = 1'b1;
        x          = '0;
        y          = '0;
        rng        = 32'h8b6e_3323;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        repeat (RST_CYCLES - 1) @(posedge CLK);
        @(negedge CLK);
        check_cleared();
        report_test(0, "reset");
        @(posedge CLK);
        #(DRIVE_DELAY);
        RST = 1'b0;
        for (int t = 0; t < NUM_FRAMES; t++) begin
            e         = FRAME_TABLE[t];
            what      = kind_name(e.kind);
            test_errs = 0;
            build_frame(e);
            model_search(frame_x, frame_y, m1x, m1y, m2x, m2y, m_cov);
            exp_cov = (e.exp_cov >= 0) ? e.exp_cov : m_cov;
            load_frame();
            wait_done(seen);
            if (!seen) begin
                $display("test %0d %s: done did not arrive within %0d cycles",
                         t + 1, what, FRAME_CYCLES);
                fail_count++;
                break;
            end
            check_centres(m1x, m1y, m2x, m2y);
            dut_cov = cover_count(frame_x, frame_y, int'(c1_x), int'(c1_y),
                                  int'(c2_x), int'(c2_y), 1'b1);
            check_count("coverage", point_cnt_t'(dut_cov), point_cnt_t'(exp_cov));
            @(posedge CLK);
            @(negedge CLK);
            check_flag("done", done, 1'b0);          // one-cycle pulse, centres still held.
            check_centres(m1x, m1y, m2x, m2y);
            report_test(t + 1, what);
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with frames still unfinished", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verif
design/laser_geom_pkg.sv
design/laser_ctrl_pkg.sv
design/cover_if.sv
design/point_buffer.sv
design/cover_counter.sv
design/center_search.sv
design/laser.sv
verif/laser_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module laser_tb \
    -f verilog.f -o laser_sim
./obj_dir/laser_sim | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi
